// File: all.f
common/ahb_pkg.sv
common/soc_map_pkg.sv
source/ahb_addr_decoder.sv
ahb_matrix/ahb_master_arbiter.sv
ahb_matrix/ahb_bus_switch.sv
ahb_matrix/ahb_matrix_top.sv
sim/tb_ahb_matrix.sv

// File: Bender.yml
package:
  name: ahb_matrix

sources:
  - files:
      - common/ahb_pkg.sv
      - common/soc_map_pkg.sv
      - source/ahb_addr_decoder.sv
      - ahb_matrix/ahb_master_arbiter.sv
      - ahb_matrix/ahb_bus_switch.sv
      - ahb_matrix/ahb_matrix_top.sv
  - target: test
    files:
      - sim/tb_ahb_matrix.sv

// File: sim/tb_ahb_matrix.sv
// ahb-lite matrix testbench with clock, reset, random masters, slave models and checks
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_matrix;

   localparam int          xfers_per_mst = 200;
   localparam int unsigned timeout_ns    = 400 * 12 * 40;

   // system address map where the lowest matching region wins
   localparam logic [31:0] map_base [10] = '{
      32'h0000_0000, 32'h2000_0000, 32'h4000_0000, 32'h4000_0100, 32'h4000_0200,
      32'h4000_0300, 32'h4000_0400, 32'h4000_1000, 32'h4000_2000, 32'h5000_0000
   };
   localparam logic [31:0] map_mask [10] = '{
      32'hE000_0000, 32'hE000_0000, 32'hFFFF_FFE0, 32'hFFFF_FFE0, 32'hFFFF_FFE0,
      32'hFFFF_FFE0, 32'hFFFF_FFC0, 32'hFFFF_F000, 32'hFFFF_F000, 32'hFFFF_F000
   };
   localparam logic [31:0] holes [4] = '{  // addresses no region claims
      32'h4000_0020, 32'h4000_0800, 32'h6000_0000, 32'hC000_0010
   };

   logic                          hclk_i;
   logic                          rst_n_i;
   ahb_pkg::ahb_mreq_t            mreq_drv [2];
   ahb_pkg::ahb_mreq_t [1:0]      mst_req;
   ahb_pkg::ahb_mrsp_t [1:0]      mst_rsp;
   ahb_pkg::ahb_sreq_t [9:0]      slv_req;
   wire ahb_pkg::ahb_srsp_t [9:0] slv_rsp;
   logic [31:0]                   ref_mem [logic [31:0]];  // reference memory
   logic [31:0]                   first_addr;              // first address of master 0

   assign mst_req[0] = mreq_drv[0];
   assign mst_req[1] = mreq_drv[1];

   ahb_matrix_top ahb_matrix_top_inst (
      .hclk_i    ( hclk_i  ),
      .rst_n_i   ( rst_n_i ),
      .mst_req_i ( mst_req ),
      .mst_rsp_o ( mst_rsp ),
      .slv_req_o ( slv_req ),
      .slv_rsp_i ( slv_rsp )
   );

   initial begin
      hclk_i = 1'b0;
      forever #20 hclk_i = ~hclk_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference helpers
   ////////////////////////////////////////////////////////////////////////////

   // unwritten words read back as a pattern of their address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return {addr[15:0], addr[31:16]} ^ 32'hC3C3_5A5A;
   endfunction

   function automatic int ref_decode(input logic [31:0] addr);
      for (int i = 0; i < 10; i++) begin
         if ((addr & map_mask[i]) == map_base[i]) begin
            return i;
         end
      end
      return -1;                                   // unmapped
   endfunction

   // one address in ten falls into a hole
   function automatic logic [31:0] pick_addr();
      if ($urandom_range(9, 0) == 0) begin
         return holes[$urandom_range(3, 0)];
      end
      return map_base[$urandom_range(9, 0)] + 32'($urandom_range(3, 0) * 4);
   endfunction

   function automatic logic [9:0] hsel_now();
      logic [9:0] v;
      for (int s = 0; s < 10; s++) begin
         v[s] = slv_req[s].hsel;
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("error in %s: expected %h actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // slave models
   ////////////////////////////////////////////////////////////////////////////

   for (genvar s = 0; s < 10; s++) begin : g_slave
      logic [31:0]        mem [logic [31:0]];
      ahb_pkg::ahb_srsp_t srsp = '{hrdata: 32'h0, hreadyout: 1'b1, hresp: ahb_pkg::OKAY};
      ahb_pkg::ahb_sreq_t seen;
      logic               seen_rst_n;
      logic               busy = 1'b0;
      logic               wr;
      logic [31:0]        addr;
      int                 wait_left = 0;

      assign slv_rsp[s] = srsp;

      always begin
         @(negedge hclk_i);                        // sample where the bus is stable
         seen       = slv_req[s];
         seen_rst_n = rst_n_i;
         @(posedge hclk_i);
         #2;
         if (!seen_rst_n) begin
            busy = 1'b0;
         end else begin
            if (busy && wait_left == 0) begin      // data phase ended at this edge
               if (wr) begin
                  mem[addr] = seen.hwdata;
               end
               busy = 1'b0;
            end else if (busy) begin
               wait_left--;
            end
            if (seen.hsel && seen.htrans[1] && seen.hready) begin
               busy        = 1'b1;
               wr          = seen.hwrite;
               addr        = seen.haddr;
               wait_left   = $urandom_range(3, 0);
               srsp.hrdata = mem.exists(addr) ? mem[addr] : fill_word(addr);
            end
         end
         srsp.hreadyout = !busy || (wait_left == 0);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // masters
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_master(input int m);
      ahb_pkg::ahb_mrsp_t rsp;
      logic [31:0]        addr;
      logic [31:0]        wdata;
      logic [31:0]        exp_data;
      logic               wr;
      int                 exp_slv;
      int                 chk;
      int                 cyc;
      bit                 first;
      for (int n = 0; n < xfers_per_mst; n++) begin
         if (n != 0) begin
            repeat ($urandom_range(3, 0)) begin    // idle gap
               @(posedge hclk_i);
               #2;
            end
         end
         addr    = pick_addr();
         wr      = 1'($urandom_range(1, 0));
         wdata   = $urandom;
         exp_slv = ref_decode(addr);
         chk     = (exp_slv < 0) ? 0 : exp_slv;
         if (m == 0 && n == 0) begin
            first_addr = addr;
         end
         mreq_drv[m].htrans = ahb_pkg::NONSEQ;
         mreq_drv[m].haddr  = addr;
         mreq_drv[m].hwrite = wr;
         first = 1'b1;
         do begin                                  // address phase
            @(negedge hclk_i);
            rsp = mst_rsp[m];
            // both start together and master 0 goes first
            if (m == 1 && n == 0 && first) begin
               check_value("arbitration hready", 32'd0, 32'(rsp.hready));
               check_value("arbitration haddr", first_addr, slv_req[0].haddr);
            end
            first = 1'b0;
            if (rsp.hready) begin
               check_value("decode hsel", (exp_slv < 0) ? 32'd0 : (32'd1 << exp_slv),
                           32'(hsel_now()));
               check_value("decode haddr", addr, slv_req[chk].haddr);
               check_value("decode hwrite", 32'(wr), 32'(slv_req[chk].hwrite));
               check_value("decode hsize", 32'(ahb_pkg::WORD), 32'(slv_req[chk].hsize));
               check_value("decode hprot", 32'(4'b0011), 32'(slv_req[chk].hprot));
            end
            @(posedge hclk_i);
            #2;
         end while (!rsp.hready);
         mreq_drv[m].htrans = ahb_pkg::IDLE;
         mreq_drv[m].hwdata = wdata;
         cyc = 0;
         do begin                                  // data phase
            @(negedge hclk_i);
            rsp = mst_rsp[m];
            if (exp_slv < 0) begin
               check_value("unmapped hresp", 32'(ahb_pkg::ERROR), 32'(rsp.hresp));
               check_value("unmapped hready", 32'(cyc != 0), 32'(rsp.hready));
            end else begin
               check_value("mapped hresp", 32'(ahb_pkg::OKAY), 32'(rsp.hresp));
            end
            cyc++;
            @(posedge hclk_i);
            #2;
         end while (!rsp.hready);
         if (exp_slv >= 0 && wr) begin
            ref_mem[addr] = wdata;
         end else if (exp_slv >= 0) begin
            exp_data = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
            check_value("read data", exp_data, rsp.hrdata);
         end
      end
   endtask

   initial begin
      void'($urandom(32'h02c9_a752));
      rst_n_i = 1'b0;
      for (int m = 0; m < 2; m++) begin
         mreq_drv[m]        = '0;
         mreq_drv[m].htrans = ahb_pkg::IDLE;
         mreq_drv[m].hsize  = ahb_pkg::WORD;
         mreq_drv[m].hprot  = 4'b0011;
      end
      repeat (3) @(posedge hclk_i);
      #2;
      rst_n_i = 1'b1;
      @(negedge hclk_i);                           // bus state right after reset
      check_value("reset hsel", 32'd0, 32'(hsel_now()));
      for (int m = 0; m < 2; m++) begin
         check_value("reset hready", 32'd1, 32'(mst_rsp[m].hready));
         check_value("reset hresp", 32'(ahb_pkg::OKAY), 32'(mst_rsp[m].hresp));
      end
      @(posedge hclk_i);
      #2;
      fork
         run_master(0);
         run_master(1);
      join
      $display("Test passed");
      $finish;
   end

   // watchdog
   initial begin
      #(timeout_ns);
      $display("timeout, the transfers did not complete within %0d ns", timeout_ns);
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: ahb_matrix/ahb_matrix_top.sv
// two-master ten-slave ahb-lite matrix top, decoders, arbiter and switch
`timescale 1ns/1ps
`default_nettype none

module ahb_matrix_top (
   input  wire logic                                          hclk_i,
   input  wire logic                                          rst_n_i,
   input  ahb_pkg::ahb_mreq_t [soc_map_pkg::num_masters-1:0]  mst_req_i,
   output ahb_pkg::ahb_mrsp_t [soc_map_pkg::num_masters-1:0]  mst_rsp_o,
   output ahb_pkg::ahb_sreq_t [soc_map_pkg::num_slaves-1:0]   slv_req_o,
   input  ahb_pkg::ahb_srsp_t [soc_map_pkg::num_slaves-1:0]   slv_rsp_i
);

   logic [soc_map_pkg::num_masters-1:0]                   mst_active;
   logic [soc_map_pkg::num_masters-1:0]                   grant;
   soc_map_pkg::dec_result_t [soc_map_pkg::num_masters-1:0] dec;
   logic                                                  bus_ready;

   // one decoder per master, both run in parallel with the arbiter
   for (genvar m = 0; m < soc_map_pkg::num_masters; m++) begin : g_dec
      assign mst_active[m] = mst_req_i[m].htrans[1];  // NONSEQ or SEQ

      ahb_addr_decoder ahb_addr_decoder_inst (
         .haddr_i  ( mst_req_i[m].haddr ),
         .result_o ( dec[m]             )
      );
   end

   ahb_master_arbiter ahb_master_arbiter_inst (
      .hclk_i      ( hclk_i     ),
      .rst_n_i     ( rst_n_i    ),
      .req_i       ( mst_active ),
      .bus_ready_i ( bus_ready  ),
      .grant_o     ( grant      )
   );

   ahb_bus_switch ahb_bus_switch_inst (
      .hclk_i      ( hclk_i     ),
      .rst_n_i     ( rst_n_i    ),
      .mst_req_i   ( mst_req_i  ),
      .mst_rsp_o   ( mst_rsp_o  ),
      .grant_i     ( grant      ),
      .dec_i       ( dec        ),
      .slv_req_o   ( slv_req_o  ),
      .slv_rsp_i   ( slv_rsp_i  ),
      .bus_ready_o ( bus_ready  )  // also drives every slave hready
   );

endmodule

`default_nettype wire

// File: ahb_matrix/ahb_bus_switch.sv
// bus switch: address/data phase routing, data-phase tracking, default error slave
`timescale 1ns/1ps
`default_nettype none

module ahb_bus_switch (
   input  wire logic                                                   hclk_i,
   input  wire logic                                                   rst_n_i,
   input  ahb_pkg::ahb_mreq_t         [soc_map_pkg::num_masters-1:0]   mst_req_i,
   output ahb_pkg::ahb_mrsp_t         [soc_map_pkg::num_masters-1:0]   mst_rsp_o,
   input  wire logic                  [soc_map_pkg::num_masters-1:0]   grant_i,
   input  soc_map_pkg::dec_result_t   [soc_map_pkg::num_masters-1:0]   dec_i,
   output ahb_pkg::ahb_sreq_t         [soc_map_pkg::num_slaves-1:0]    slv_req_o,
   input  ahb_pkg::ahb_srsp_t         [soc_map_pkg::num_slaves-1:0]    slv_rsp_i,
   output logic                                                        bus_ready_o
);

   typedef enum logic [1:0] {
      IDLE,
      ERR_FIRST,   // error with bus-ready low
      ERR_SECOND   // error with bus-ready high
   } dflt_state_e;

   dflt_state_e                        err_q;
   dflt_state_e                        err_d;

   soc_map_pkg::mst_idx_t              gnt_idx;
   ahb_pkg::ahb_mreq_t                 a_req;
   soc_map_pkg::dec_result_t           a_dec;
   logic                               a_active;
   logic                               a_accept;
   logic [soc_map_pkg::num_slaves-1:0] hsel_vec;

   logic                               dp_open;  // a data phase is in flight
   soc_map_pkg::mst_idx_t              dp_mst;
   soc_map_pkg::slv_idx_t              dp_slv;
   ahb_pkg::hresp_e                    dp_hresp;
   logic                               owns_dp;

   ////////////////////////////////////////////////////////////////////////////
   // address phase
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      gnt_idx = '0;
      for (int m = 0; m < soc_map_pkg::num_masters; m++) begin
         if (grant_i[m]) begin
            gnt_idx = soc_map_pkg::mst_idx_t'(m);
         end
      end
   end

   assign a_req    = mst_req_i[gnt_idx];
   assign a_dec    = dec_i[gnt_idx];
   assign a_active = a_req.htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ};
   assign a_accept = a_active && bus_ready_o;

   always_comb begin
      for (int s = 0; s < soc_map_pkg::num_slaves; s++) begin
         hsel_vec[s]            = a_active && a_dec.hit &&
                                  (a_dec.slv == soc_map_pkg::slv_idx_t'(s));
         slv_req_o[s].hsel      = hsel_vec[s];
         slv_req_o[s].haddr     = a_req.haddr;   // address fields go to every slave
         slv_req_o[s].htrans    = a_req.htrans;
         slv_req_o[s].hwrite    = a_req.hwrite;
         slv_req_o[s].hsize     = a_req.hsize;
         slv_req_o[s].hburst    = a_req.hburst;
         slv_req_o[s].hprot     = a_req.hprot;
         slv_req_o[s].hwdata    = mst_req_i[dp_mst].hwdata; // data-phase owner
         slv_req_o[s].hready    = bus_ready_o;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // data phase and default slave
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (err_q)
         ERR_FIRST:  bus_ready_o = 1'b0;
         ERR_SECOND: bus_ready_o = 1'b1;
         default:    bus_ready_o = dp_open ? slv_rsp_i[dp_slv].hreadyout : 1'b1;
      endcase
   end

   always_comb begin
      case (err_q)
         ERR_FIRST: err_d = ERR_SECOND;
         default:   err_d = (a_accept && !a_dec.hit) ? ERR_FIRST : IDLE;
      endcase
   end

   assign dp_hresp = (err_q != IDLE) ? ahb_pkg::ERROR :
                     dp_open         ? slv_rsp_i[dp_slv].hresp : ahb_pkg::OKAY;

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         err_q   <= IDLE;
         dp_open <= 1'b0;
         dp_mst  <= '0;
         dp_slv  <= '0;
      end else begin
         err_q <= err_d;
         if (bus_ready_o) begin     // address phase accepted or bus idle
            dp_open <= a_active;
            dp_mst  <= gnt_idx;
            dp_slv  <= a_dec.slv;
         end
      end
   end

   // per-master response
   always_comb begin
      for (int m = 0; m < soc_map_pkg::num_masters; m++) begin
         owns_dp             = dp_open && (dp_mst == soc_map_pkg::mst_idx_t'(m));
         mst_rsp_o[m].hrdata = slv_rsp_i[dp_slv].hrdata;
         mst_rsp_o[m].hresp  = owns_dp ? dp_hresp : ahb_pkg::OKAY;
         if (owns_dp || grant_i[m]) begin
            mst_rsp_o[m].hready = bus_ready_o;
         end else if (mst_req_i[m].htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ}) begin
            mst_rsp_o[m].hready = 1'b0;  // waiting for the grant
         end else begin
            mst_rsp_o[m].hready = 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   hsel_onehot_a : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      $onehot0(hsel_vec));

endmodule

`default_nettype wire

// File: ahb_matrix/ahb_master_arbiter.sv
// fixed-priority master arbiter with grant hold on an idle bus
`timescale 1ns/1ps
`default_nettype none

module ahb_master_arbiter (
   input  wire logic                                hclk_i,
   input  wire logic                                rst_n_i,
   input  wire logic [soc_map_pkg::num_masters-1:0] req_i,
   input  wire logic                                bus_ready_i,
   output logic      [soc_map_pkg::num_masters-1:0] grant_o
);

   soc_map_pkg::mst_idx_t owner_q;  // last owner of the address phase
   soc_map_pkg::mst_idx_t owner_d;
   soc_map_pkg::mst_idx_t best;
   logic [2:0]            best_pri;
   logic                  found;

   // highest priority requester, ties go to the lower index
   always_comb begin
      found    = 1'b0;
      best     = owner_q;
      best_pri = '0;
      for (int m = 0; m < soc_map_pkg::num_masters; m++) begin
         if (req_i[m] && (!found || (soc_map_pkg::mst_priority[m] > best_pri))) begin
            found    = 1'b1;
            best     = soc_map_pkg::mst_idx_t'(m);
            best_pri = soc_map_pkg::mst_priority[m];
         end
      end
   end

   // grant only moves while the bus can take an address
   assign owner_d = (bus_ready_i && found) ? best : owner_q;

   always_comb begin
      grant_o          = '0;
      grant_o[owner_d] = 1'b1;
   end

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         owner_q <= '0;             // master 0 holds the bus out of reset
      end else if (bus_ready_i) begin
         owner_q <= owner_d;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   grant_onehot_a : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      $onehot(grant_o));

   // stalled slave freezes the owner across cycles
   grant_stall_a : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      !bus_ready_i |-> $stable(grant_o));

endmodule

`default_nettype wire

// File: source/ahb_addr_decoder.sv
// address decoder, one master's haddr to slave index and hit flag
`timescale 1ns/1ps
`default_nettype none

module ahb_addr_decoder (
   input  wire logic [ahb_pkg::haddr_width-1:0] haddr_i,
   output soc_map_pkg::dec_result_t             result_o
);

   logic [soc_map_pkg::num_slaves-1:0] region_hit;

   // one compare per region
   always_comb begin
      for (int i = 0; i < soc_map_pkg::num_slaves; i++) begin
         region_hit[i] = (haddr_i & soc_map_pkg::slv_mask[i]) == soc_map_pkg::slv_base[i];
      end
   end

   // walk downwards so the lowest hitting region is written last
   always_comb begin
      result_o.hit = 1'b0;
      result_o.slv = '0;
      for (int i = soc_map_pkg::num_slaves - 1; i >= 0; i--) begin
         if (region_hit[i]) begin
            result_o.hit = 1'b1;
            result_o.slv = soc_map_pkg::slv_idx_t'(i);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   // a hit never names a slave port that does not exist
   always_comb begin
      assert final (!result_o.hit || (result_o.slv < soc_map_pkg::num_slaves))
         else $error("decoder hit on slave index %0d", result_o.slv);
   end

endmodule

`default_nettype wire

// File: common/soc_map_pkg.sv
// master and slave counts, master priorities and slave address map
`default_nettype none

package soc_map_pkg;

   localparam int unsigned num_masters = 2;
   localparam int unsigned num_slaves  = 10;

   typedef logic [0:0] mst_idx_t;
   typedef logic [3:0] slv_idx_t;

   // cpu core first, dma second
   localparam logic [2:0] mst_priority [num_masters] = '{3'd7, 3'd1};

   // region i hits when (haddr & slv_mask[i]) == slv_base[i]
   localparam logic [ahb_pkg::haddr_width-1:0] slv_base [num_slaves] = '{
      32'h0000_0000, 32'h2000_0000,                   // rom, ram
      32'h4000_0000, 32'h4000_0100,
      32'h4000_0200, 32'h4000_0300,                   // small register blocks
      32'h4000_0400,                                  // timer
      32'h4000_1000, 32'h4000_2000,                   // generic memories
      32'h5000_0000                                   // dma registers
   };

   localparam logic [ahb_pkg::haddr_width-1:0] slv_mask [num_slaves] = '{
      32'hE000_0000, 32'hE000_0000,
      32'hFFFF_FFE0, 32'hFFFF_FFE0,
      32'hFFFF_FFE0, 32'hFFFF_FFE0,
      32'hFFFF_FFC0,
      32'hFFFF_F000, 32'hFFFF_F000,
      32'hFFFF_F000
   };

   typedef struct packed {
      logic     hit;
      slv_idx_t slv;
   } dec_result_t;

endpackage

`default_nettype wire

// File: common/ahb_pkg.sv
// ahb-lite bus widths, transfer enums and request/response structs
`default_nettype none

package ahb_pkg;

   localparam int unsigned haddr_width = 32;
   localparam int unsigned hdata_width = 32;

   // bit 1 set marks an active transfer
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   typedef enum logic {
      OKAY  = 1'b0,
      ERROR = 1'b1
   } hresp_e;

   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_e;

   ////////////////////////////////////////////////////////////////////////////
   // master side
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [haddr_width-1:0] haddr;
      htrans_e                htrans;
      logic                   hwrite;
      hsize_e                 hsize;
      logic [2:0]             hburst; // passed through, no burst handling
      logic [3:0]             hprot;
      logic [hdata_width-1:0] hwdata; // valid one cycle after its address
   } ahb_mreq_t;

   typedef struct packed {
      logic [hdata_width-1:0] hrdata;
      logic                   hready;
      hresp_e                 hresp;
   } ahb_mrsp_t;

   ////////////////////////////////////////////////////////////////////////////
   // slave side
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                   hsel;
      logic [haddr_width-1:0] haddr;
      htrans_e                htrans;
      logic                   hwrite;
      hsize_e                 hsize;
      logic [2:0]             hburst;
      logic [3:0]             hprot;
      logic [hdata_width-1:0] hwdata;
      logic                   hready; // shared bus-ready
   } ahb_sreq_t;

   typedef struct packed {
      logic [hdata_width-1:0] hrdata;
      logic                   hreadyout;
      hresp_e                 hresp;
   } ahb_srsp_t;

endpackage

`default_nettype wire
